// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP       := tb_integer_issue
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above

SHELL := /bin/bash

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/iiq_cases.txt
# name dv s1v s1r s1id s1data s2v s2r s2id s2data rob_id alu_v alu_id alu_data ld_v ld_id ld_data flush
# expected: dispatch_ready issue_valid issue_rob_id entry_valid src1_data src2_data (all hex)
reset      0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  1 0 0  0 0        0
no_src     1 0 0 0  0 0 0 0 0 1   0 0 0        0 0  0        0  1 0 0  0 0        0
no_src     1 0 0 0  0 0 0 0 0 2   0 0 0        0 0  0        0  1 1 1  0 0        0
no_src     1 0 0 0  0 0 0 0 0 3   0 0 0        0 0  0        0  1 1 2  1 0        0
no_src     0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  1 1 3  1 0        0
no_src     0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  1 0 0  1 0        0
ld_wake    1 1 0 9  0 0 0 0 0 4   0 0 0        0 0  0        0  1 0 0  0 0        0
ld_wake    0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  1 0 0  0 0        0
ld_wake    0 0 0 0  0 0 0 0 0 0   0 0 0        1 9  1234abcd 0  1 0 0  0 0        0
ld_wake    0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  1 1 4  0 0        0
ld_wake    0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  1 0 0  1 1234abcd 0
alu_bypass 1 1 0 a  0 0 0 0 0 5   0 0 0        0 0  0        0  1 0 0  0 0        0
alu_bypass 1 1 0 5  0 0 0 0 0 6   0 0 0        0 0  0        0  1 0 0  0 0        0
alu_bypass 0 0 0 0  0 0 0 0 0 0   0 0 0        1 a  55       0  1 0 0  0 0        0
alu_bypass 0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  1 1 5  0 0        0
alu_bypass 0 0 0 0  0 0 0 0 0 0   1 5 cafe0005 0 0  0        0  1 1 6  1 55       0
alu_bypass 0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  1 0 0  1 cafe0005 0
full       1 1 0 18 0 0 0 0 0 10  0 0 0        0 0  0        0  1 0 0  0 0        0
full       1 1 0 19 0 0 0 0 0 11  0 0 0        0 0  0        0  1 0 0  0 0        0
full       1 1 0 1a 0 0 0 0 0 12  0 0 0        0 0  0        0  1 0 0  0 0        0
full       1 1 0 1b 0 0 0 0 0 13  0 0 0        0 0  0        0  1 0 0  0 0        0
full       1 1 0 1c 0 0 0 0 0 14  0 0 0        0 0  0        0  1 0 0  0 0        0
full       1 1 0 1d 0 0 0 0 0 15  0 0 0        0 0  0        0  1 0 0  0 0        0
full       1 1 0 1e 0 0 0 0 0 16  0 0 0        0 0  0        0  1 0 0  0 0        0
full       1 1 0 1f 0 0 0 0 0 17  0 0 0        0 0  0        0  1 0 0  0 0        0
full       1 0 0 0  0 0 0 0 0 1   0 0 0        1 18 77       0  0 0 0  0 0        0
full       1 0 0 0  0 0 0 0 0 1   0 0 0        0 0  0        0  0 1 10 0 0        0
full       1 0 0 0  0 0 0 0 0 1   0 0 0        0 0  0        0  1 0 0  1 77       0
full       0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  0 1 1  0 0        0
full       0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  1 0 0  1 0        0
flush      0 0 0 0  0 0 0 0 0 0   0 0 0        1 19 99       0  1 0 0  0 0        0
flush      0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        1  1 1 11 0 0        0
flush      0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  1 0 0  0 0        0
flush      0 0 0 0  0 0 0 0 0 0   0 0 0        1 1a 1        0  1 0 0  0 0        0
flush      0 0 0 0  0 0 0 0 0 0   0 0 0        0 0  0        0  1 0 0  0 0        0

// File: bench/tb_integer_issue.sv
`timescale 1ns/10ps
`default_nettype none

module tb_integer_issue
    import core_types_pkg::*;
    import iiq_pkg::*;
();
    localparam string CASES_FILE = "bench/iiq_cases.txt";

    logic            clk;
    logic            rst;
    logic            dispatch_ready;
    logic            dispatch_valid;
    iiq_entry_t      dispatch_data;
    logic            issue_valid;
    rob_id_t         issue_rob_id;
    iiq_issue_data_t issue_data;
    logic            alu_broadcast_valid;
    rob_id_t         alu_broadcast_rob_id;
    reg_data_t       alu_broadcast_reg_data;
    logic            ld_broadcast_valid;
    rob_id_t         ld_broadcast_rob_id;
    reg_data_t       ld_broadcast_reg_data;
    logic            fetch_redirect_valid;

    string case_lines[$];
    string cur_test = "";
    int    line_idx = 0;
    int    test_errors = 0;
    int    total_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;
    logic [31:0] prev_issue_rob_id = '0;

    integer_issue uut (
        .clk                    (clk),
        .rst                    (rst),
        .dispatch_ready         (dispatch_ready),
        .dispatch_valid         (dispatch_valid),
        .dispatch_data          (dispatch_data),
        .issue_valid            (issue_valid),
        .issue_rob_id           (issue_rob_id),
        .issue_data             (issue_data),
        .alu_broadcast_valid    (alu_broadcast_valid),
        .alu_broadcast_rob_id   (alu_broadcast_rob_id),
        .alu_broadcast_reg_data (alu_broadcast_reg_data),
        .ld_broadcast_valid     (ld_broadcast_valid),
        .ld_broadcast_rob_id    (ld_broadcast_rob_id),
        .ld_broadcast_reg_data  (ld_broadcast_reg_data),
        .fetch_redirect_valid   (fetch_redirect_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // bounded by the number of case lines
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic drive_idle();
        dispatch_valid         = 1'b0;
        dispatch_data          = '0;
        alu_broadcast_valid    = 1'b0;
        alu_broadcast_rob_id   = '0;
        alu_broadcast_reg_data = '0;
        ld_broadcast_valid     = 1'b0;
        ld_broadcast_rob_id    = '0;
        ld_broadcast_reg_data  = '0;
        fetch_redirect_valid   = 1'b0;
    endtask

    // comment lines start with '#'
    task automatic load_cases(output bit ok);
        int    fd;
        int    r;
        string text;
        ok = 1'b0;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("cannot open case file %s", CASES_FILE);
        end else begin
            while (!$feof(fd)) begin
                text = "";
                r = $fgets(text, fd);
                if (r > 0 && text.len() > 1 && text.getc(0) != "#") begin
                    case_lines.push_back(text);
                end
            end
            $fclose(fd);
            ok = case_lines.size() > 0;
            if (!ok) begin
                $display("case file %s holds no cases", CASES_FILE);
            end
        end
    endtask

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s %s (line %0d): expected %h, actual %h",
                     cur_test, what, line_idx, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", cur_test, test_errors);
        end
    endtask

    // drive one cycle at the falling edge, check mid low phase
    task automatic apply_line(input string text);
        string       name;
        logic [31:0] f [0:22];
        iiq_entry_t  entry;
        int          n;
        n = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16],
                    f[17], f[18], f[19], f[20], f[21], f[22]);
        if (n != 24) begin
            $display("case line %0d could not be parsed", line_idx);
            total_errors++;
        end else begin
            if (name != cur_test) begin
                if (cur_test != "") begin
                    close_test();
                end
                cur_test    = name;
                test_errors = 0;
            end
            entry              = '0;
            entry.src1.valid   = f[1][0];
            entry.src1.ready   = f[2][0];
            entry.src1.rob_id  = rob_id_t'(f[3]);
            entry.src1.data    = f[4];
            entry.src2.valid   = f[5][0];
            entry.src2.ready   = f[6][0];
            entry.src2.rob_id  = rob_id_t'(f[7]);
            entry.src2.data    = f[8];
            entry.instr_rob_id = rob_id_t'(f[9]);
            entry.funct3       = f[9][2:0];
            entry.imm          = f[9];

            dispatch_valid         = f[0][0];
            dispatch_data          = entry;
            alu_broadcast_valid    = f[10][0];
            alu_broadcast_rob_id   = rob_id_t'(f[11]);
            alu_broadcast_reg_data = f[12];
            ld_broadcast_valid     = f[13][0];
            ld_broadcast_rob_id    = rob_id_t'(f[14]);
            ld_broadcast_reg_data  = f[15];
            fetch_redirect_valid   = f[16][0];

            #5;
            compare("dispatch_ready", f[17], 32'(dispatch_ready));
            compare("issue_valid", f[18], 32'(issue_valid));
            compare("issue_rob_id", f[19], 32'(issue_rob_id));
            compare("entry_valid", f[20], 32'(issue_data.entry_valid));
            compare("src1_data", f[21], issue_data.src1_data);
            compare("src2_data", f[22], issue_data.src2_data);

            // issue register holds the instruction picked one cycle earlier,
            // whose funct3 and imm were dispatched from its rob id
            if (f[20][0]) begin
                compare("issue_data.rob_id", prev_issue_rob_id, 32'(issue_data.rob_id));
                compare("funct3", 32'(prev_issue_rob_id[2:0]), 32'(issue_data.funct3));
                compare("imm", prev_issue_rob_id, issue_data.imm);
            end
            prev_issue_rob_id = f[19];
        end
    endtask

    initial begin : main
        bit loaded;
        rst = 1'b1;
        drive_idle();
        load_cases(loaded);
        if (!loaded) begin
            $display("FAIL: see errors above");
            $finish;
        end else begin
            cycle_limit = case_lines.size() + 20;
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            foreach (case_lines[i]) begin
                line_idx = i + 1;
                apply_line(case_lines[i]);
                @(negedge clk);
            end
            if (cur_test != "") begin
                close_test();
            end
            $display("%0d tests run, %0d failed, %0d mismatches",
                     tests_run, tests_failed, total_errors);
            if (total_errors == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/core_types_pkg.sv
rtl/iiq_pkg.sv
rtl/iiq_entry_array.sv
rtl/iiq_operand_update.sv
rtl/iiq_select.sv
rtl/iiq_issue_stage.sv
rtl/integer_issue.sv
bench/tb_integer_issue.sv

// File: rtl/core_types_pkg.sv
`default_nettype none
`include "iiq_consts.svh"

package core_types_pkg;

    // tag of an in-flight instruction in the ROB
    typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t;

    // one register value as seen by the execution units
    typedef logic [`REG_DATA_WIDTH-1:0] reg_data_t;

endpackage

`default_nettype wire

// File: rtl/iiq_consts.svh
`ifndef IIQ_CONSTS_SVH
`define IIQ_CONSTS_SVH

// queue depth, counter must hold 0..depth
`define IIQ_N_ENTRIES  8
`define IIQ_CTR_WIDTH  4

// tag and payload widths
`define ROB_ID_WIDTH   5
`define REG_DATA_WIDTH 32
`define IIQ_IMM_WIDTH  32

`endif

// File: rtl/iiq_entry_array.sv
`timescale 1ns/10ps
`default_nettype none
`include "iiq_consts.svh"

module iiq_entry_array
    import iiq_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                enq_valid,
    input  iiq_entry_t                          enq_data,
    output logic                                enq_ready,
    input  logic       [`IIQ_N_ENTRIES-1:0]     deq_sel_onehot,
    input  logic       [`IIQ_N_ENTRIES-1:0]     wr_en,
    input  iiq_entry_t [`IIQ_N_ENTRIES-1:0]     wr_data,
    output iiq_entry_t [`IIQ_N_ENTRIES-1:0]     entries,
    output logic       [`IIQ_N_ENTRIES-1:0]     entries_valid,
    output iiq_entry_t                          deq_data,
    output logic                                deq_valid
);
    localparam int unsigned N     = `IIQ_N_ENTRIES;
    localparam int unsigned CTR_W = `IIQ_CTR_WIDTH;

    logic [CTR_W-1:0]   count;
    logic [CTR_W-1:0]   tail_idx;
    logic               enq_fire;
    logic [N-1:0]       shift_mask;
    iiq_entry_t [N:0]   upd_entries;
    iiq_entry_t [N-1:0] next_entries;

    assign enq_ready = count < CTR_W'(N);
    assign enq_fire  = enq_valid & enq_ready;
    assign deq_valid = |deq_sel_onehot;

    // new entry lands behind the survivors of this cycle's dequeue
    assign tail_idx = count - CTR_W'(deq_valid);

    // oldest entries sit at the low indices
    always_comb begin : valid_decode
        for (int i = 0; i < N; i++) begin
            entries_valid[i] = CTR_W'(i) < count;
        end
    end

    always_comb begin : deq_mux
        deq_data = '0;
        for (int i = 0; i < N; i++) begin
            if (deq_sel_onehot[i]) begin
                deq_data = entries[i];
            end
        end
    end

    // every slot at or above the dequeued one moves down
    always_comb begin : shift_decode
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < N; i++) begin
            seen          = seen | deq_sel_onehot[i];
            shift_mask[i] = seen;
        end
    end

    always_comb begin : next_state
        for (int i = 0; i < N; i++) begin
            upd_entries[i] = wr_en[i] ? wr_data[i] : entries[i];
        end
        // only reaches the top slot when full, which blocks enqueue anyway
        upd_entries[N] = enq_data;
        for (int i = 0; i < N; i++) begin
            next_entries[i] = shift_mask[i] ? upd_entries[i+1] : upd_entries[i];
            if (enq_fire && tail_idx == CTR_W'(i)) begin
                next_entries[i] = enq_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        entries <= next_entries;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            count <= '0;
        end else begin
            count <= count + CTR_W'(enq_fire) - CTR_W'(deq_valid);
        end
    end

    // select logic must pick at most one slot, and only a live one
    a_deq_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(deq_sel_onehot))
        else $error("iiq_entry_array: dequeue select is not one-hot");

    a_deq_live: assert property (@(posedge clk) disable iff (rst)
        (deq_sel_onehot & ~entries_valid) == '0)
        else $error("iiq_entry_array: dequeue of an empty slot");

endmodule

`default_nettype wire

// File: rtl/iiq_issue_stage.sv
`timescale 1ns/10ps
`default_nettype none

module iiq_issue_stage
    import core_types_pkg::*;
    import iiq_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            issue_valid,
    input  iiq_entry_t      sched_entry,
    input  logic            alu_broadcast_valid,
    input  rob_id_t         alu_broadcast_rob_id,
    input  reg_data_t       alu_broadcast_reg_data,
    input  logic            ld_broadcast_valid,
    input  rob_id_t         ld_broadcast_rob_id,
    input  reg_data_t       ld_broadcast_reg_data,
    output iiq_issue_data_t issue_data
);
    iiq_issue_data_t issue_next;

    // results still on the broadcast buses are newer than the queue copy,
    // alu first, then load
    function automatic reg_data_t bypass_data(input iiq_src_t src);
        reg_data_t data;
        if (alu_broadcast_valid && alu_broadcast_rob_id == src.rob_id) begin
            data = alu_broadcast_reg_data;
        end else if (ld_broadcast_valid && ld_broadcast_rob_id == src.rob_id) begin
            data = ld_broadcast_reg_data;
        end else begin
            data = src.data;
        end
        return data;
    endfunction

    always_comb begin
        issue_next = '{
            entry_valid: issue_valid,
            src1_data:   bypass_data(sched_entry.src1),
            src2_data:   bypass_data(sched_entry.src2),
            rob_id:      sched_entry.instr_rob_id,
            funct3:      sched_entry.funct3,
            imm:         sched_entry.imm
        };
    end

    // redirect kills the instruction on its way to the alu
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            issue_data <= '0;
        end else begin
            issue_data <= issue_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/iiq_operand_update.sv
`timescale 1ns/10ps
`default_nettype none
`include "iiq_consts.svh"

module iiq_operand_update
    import core_types_pkg::*;
    import iiq_pkg::*;
(
    input  iiq_entry_t [`IIQ_N_ENTRIES-1:0]     entries,
    input  logic       [`IIQ_N_ENTRIES-1:0]     entries_valid,
    input  logic                                issue_valid,
    input  rob_id_t                             issue_rob_id,
    input  logic                                alu_broadcast_valid,
    input  rob_id_t                             alu_broadcast_rob_id,
    input  reg_data_t                           alu_broadcast_reg_data,
    input  logic                                ld_broadcast_valid,
    input  rob_id_t                             ld_broadcast_rob_id,
    input  reg_data_t                           ld_broadcast_reg_data,
    output logic       [`IIQ_N_ENTRIES-1:0]     wr_en,
    output iiq_entry_t [`IIQ_N_ENTRIES-1:0]     wr_data
);

    for (genvar i = 0; i < `IIQ_N_ENTRIES; i++) begin : g_entry
        iiq_src_t [1:0] src_cur;
        iiq_src_t [1:0] src_new;
        logic     [1:0] src_hit;

        // index 0 is src1, index 1 is src2
        assign src_cur = {entries[i].src2, entries[i].src1};

        for (genvar j = 0; j < 2; j++) begin : g_src
            logic live;
            logic wake;
            logic alu_cap;
            logic ld_cap;

            assign live = entries_valid[i] & src_cur[j].valid;

            // issuing producer, data arrives later on the alu broadcast
            assign wake = live & issue_valid & ~src_cur[j].ready
                        & (issue_rob_id == src_cur[j].rob_id);

            // alu result of a producer that woke us earlier
            assign alu_cap = live & alu_broadcast_valid & src_cur[j].ready
                           & (alu_broadcast_rob_id == src_cur[j].rob_id);

            // load result, ready and data in one step
            assign ld_cap = live & ld_broadcast_valid & ~src_cur[j].ready
                          & (ld_broadcast_rob_id == src_cur[j].rob_id);

            assign src_hit[j] = wake | alu_cap | ld_cap;

            assign src_new[j] = '{
                valid:  src_cur[j].valid,
                ready:  src_cur[j].ready | wake | ld_cap,
                rob_id: src_cur[j].rob_id,
                data:   alu_cap ? alu_broadcast_reg_data :
                        ld_cap  ? ld_broadcast_reg_data  : src_cur[j].data
            };
        end

        assign wr_en[i]   = |src_hit;
        assign wr_data[i] = '{
            src1:         src_new[0],
            src2:         src_new[1],
            instr_rob_id: entries[i].instr_rob_id,
            funct3:       entries[i].funct3,
            imm:          entries[i].imm
        };
    end

    // alu and load units never finish the same tag together,
    // otherwise capture and issue bypass would disagree on the data
    always_comb begin
        assert (!(alu_broadcast_valid && ld_broadcast_valid
                  && alu_broadcast_rob_id == ld_broadcast_rob_id))
            else $error("iiq_operand_update: alu and load broadcast share a tag");
    end

endmodule

`default_nettype wire

// File: rtl/iiq_pkg.sv
`default_nettype none
`include "iiq_consts.svh"

package iiq_pkg;
    import core_types_pkg::*;

    // one source operand waiting in the queue
    typedef struct packed {
        logic      valid;  // instruction reads this source
        logic      ready;  // producer has issued or loaded
        rob_id_t   rob_id;
        reg_data_t data;
    } iiq_src_t;

    // queue entry as written by dispatch
    typedef struct packed {
        iiq_src_t                   src1;
        iiq_src_t                   src2;
        rob_id_t                    instr_rob_id;
        logic [2:0]                 funct3;
        logic [`IIQ_IMM_WIDTH-1:0]  imm;
    } iiq_entry_t;

    // word held in the issue register, operands already resolved
    typedef struct packed {
        logic                       entry_valid;
        reg_data_t                  src1_data;
        reg_data_t                  src2_data;
        rob_id_t                    rob_id;
        logic [2:0]                 funct3;
        logic [`IIQ_IMM_WIDTH-1:0]  imm;
    } iiq_issue_data_t;

endpackage

`default_nettype wire

// File: rtl/iiq_select.sv
`timescale 1ns/10ps
`default_nettype none
`include "iiq_consts.svh"

module iiq_select
    import iiq_pkg::*;
(
    input  iiq_entry_t [`IIQ_N_ENTRIES-1:0]     entries,
    input  logic       [`IIQ_N_ENTRIES-1:0]     entries_valid,
    output logic       [`IIQ_N_ENTRIES-1:0]     deq_sel_onehot,
    output logic                                issue_valid
);
    logic [`IIQ_N_ENTRIES-1:0] entries_ready;

    // a source the instruction does not read never blocks it
    always_comb begin
        for (int i = 0; i < `IIQ_N_ENTRIES; i++) begin
            entries_ready[i] = entries_valid[i]
                             & (~entries[i].src1.valid | entries[i].src1.ready)
                             & (~entries[i].src2.valid | entries[i].src2.ready);
        end
    end

    // lowest set bit is the oldest ready entry
    assign deq_sel_onehot = entries_ready & (-entries_ready);
    assign issue_valid    = |entries_ready;

endmodule

`default_nettype wire

// File: rtl/integer_issue.sv
`timescale 1ns/10ps
`default_nettype none
`include "iiq_consts.svh"

module integer_issue
    import core_types_pkg::*;
    import iiq_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    // dispatch, valid/ready
    output logic            dispatch_ready,
    input  logic            dispatch_valid,
    input  iiq_entry_t      dispatch_data,

    // issue, no back-pressure since every op takes one cycle
    output logic            issue_valid,
    output rob_id_t         issue_rob_id,
    output iiq_issue_data_t issue_data,

    input  logic            alu_broadcast_valid,
    input  rob_id_t         alu_broadcast_rob_id,
    input  reg_data_t       alu_broadcast_reg_data,
    input  logic            ld_broadcast_valid,
    input  rob_id_t         ld_broadcast_rob_id,
    input  reg_data_t       ld_broadcast_reg_data,

    input  logic            fetch_redirect_valid
);
    iiq_entry_t [`IIQ_N_ENTRIES-1:0]    entries;
    logic       [`IIQ_N_ENTRIES-1:0]    entries_valid;
    logic       [`IIQ_N_ENTRIES-1:0]    entries_wr_en;
    iiq_entry_t [`IIQ_N_ENTRIES-1:0]    entries_wr_data;
    logic       [`IIQ_N_ENTRIES-1:0]    sched_onehot;
    logic                               sched_valid;
    iiq_entry_t                         sched_entry;

    iiq_entry_array u_entry_array (
        .clk            (clk),
        .rst            (rst),
        .flush          (fetch_redirect_valid),
        .enq_valid      (dispatch_valid),
        .enq_data       (dispatch_data),
        .enq_ready      (dispatch_ready),
        .deq_sel_onehot (sched_onehot),
        .wr_en          (entries_wr_en),
        .wr_data        (entries_wr_data),
        .entries        (entries),
        .entries_valid  (entries_valid),
        .deq_data       (sched_entry),
        .deq_valid      (issue_valid)
    );

    iiq_select u_select (
        .entries        (entries),
        .entries_valid  (entries_valid),
        .deq_sel_onehot (sched_onehot),
        .issue_valid    (sched_valid)
    );

    iiq_operand_update u_operand_update (
        .entries                (entries),
        .entries_valid          (entries_valid),
        .issue_valid            (sched_valid),
        .issue_rob_id           (issue_rob_id),
        .alu_broadcast_valid    (alu_broadcast_valid),
        .alu_broadcast_rob_id   (alu_broadcast_rob_id),
        .alu_broadcast_reg_data (alu_broadcast_reg_data),
        .ld_broadcast_valid     (ld_broadcast_valid),
        .ld_broadcast_rob_id    (ld_broadcast_rob_id),
        .ld_broadcast_reg_data  (ld_broadcast_reg_data),
        .wr_en                  (entries_wr_en),
        .wr_data                (entries_wr_data)
    );

    iiq_issue_stage u_issue_stage (
        .clk                    (clk),
        .rst                    (rst),
        .flush                  (fetch_redirect_valid),
        .issue_valid            (sched_valid),
        .sched_entry            (sched_entry),
        .alu_broadcast_valid    (alu_broadcast_valid),
        .alu_broadcast_rob_id   (alu_broadcast_rob_id),
        .alu_broadcast_reg_data (alu_broadcast_reg_data),
        .ld_broadcast_valid     (ld_broadcast_valid),
        .ld_broadcast_rob_id    (ld_broadcast_rob_id),
        .ld_broadcast_reg_data  (ld_broadcast_reg_data),
        .issue_data             (issue_data)
    );

    assign issue_rob_id = sched_entry.instr_rob_id;

endmodule

`default_nettype wire
